/* common/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// First fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

// Architectural register count
`define CPU_REG_COUNT 32

`endif

/* common/cpuPkg.sv */
package cpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluNor, aluXor,
        aluSlt, aluSll, aluSrl, aluMul, aluPassB
    } aluOp_t;

    // Branch test applied in execute
    typedef enum logic [2:0] {
        brNone, brEq, brNe, brGtz, brLez, brGez, brLtz
    } branchKind_t;

    typedef enum logic [1:0] {
        memWord, memHalf, memByte
    } memSize_t;

    //////////////////////////////////////////////////////////////////////
    // Stage handoff structs

    typedef struct packed {
        word_t pc;
        word_t instr;
        logic  valid;
    } fetchOut_t;

    typedef struct packed {
        word_t       pc;
        word_t       rsVal;
        word_t       rtVal;
        word_t       imm;
        regAddr_t    destReg;
        aluOp_t      aluOp;
        logic        aluSrc;
        branchKind_t branchKind;
        logic        jump;
        logic        jumpReg;
        logic        link;
        logic        memRead;
        logic        memWrite;
        memSize_t    memSize;
        logic        memSigned;
        logic        regWrite;
        word_t       jumpTarget;
        logic        valid;
    } decodeOut_t;

    typedef struct packed {
        word_t    result;
        word_t    storeData;
        word_t    nextPc;
        regAddr_t destReg;
        logic     memRead;
        logic     memWrite;
        memSize_t memSize;
        logic     memSigned;
        logic     regWrite;
        logic     valid;
    } execOut_t;

endpackage

/* decode/regFile.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module regFile import cpuPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  regAddr_t rsAddr,
    input  regAddr_t rtAddr,
    output word_t    rsData,
    output word_t    rtData,
    input  logic     wrEn,
    input  regAddr_t wrAddr,
    input  word_t    wrData
);

    word_t regs [`CPU_REG_COUNT];

    // Register 0 always reads as zero
    assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule

/* decode/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage import cpuPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  fetchOut_t  fetchOut,
    output regAddr_t   rsAddr,
    output regAddr_t   rtAddr,
    input  word_t      rsData,
    input  word_t      rtData,
    output decodeOut_t decodeOut
);

    word_t      instr;
    logic [5:0] opcode;
    logic [5:0] funct;
    regAddr_t   rdField;
    word_t      immSigned;
    word_t      immZero;
    decodeOut_t decodeNext;

    assign instr     = fetchOut.instr;
    assign opcode    = instr[31:26];
    assign funct     = instr[5:0];
    assign rsAddr    = instr[25:21];
    assign rtAddr    = instr[20:16];
    assign rdField   = instr[15:11];
    assign immSigned = {{16{instr[15]}}, instr[15:0]};
    assign immZero   = {16'b0, instr[15:0]};

    //////////////////////////////////////////////////////////////////////
    // Control decode, unknown opcodes fall out as no-ops

    always_comb begin
        decodeNext            = '0;
        decodeNext.pc         = fetchOut.pc;
        decodeNext.rsVal      = rsData;
        decodeNext.rtVal      = rtData;
        decodeNext.imm        = immSigned;
        decodeNext.destReg    = rtAddr;
        decodeNext.aluOp      = aluPassB;
        decodeNext.branchKind = brNone;
        decodeNext.memSize    = memWord;
        decodeNext.jumpTarget = {fetchOut.pc[31:28], instr[25:0], 2'b00};
        decodeNext.valid      = fetchOut.valid;

        case (opcode)
            6'b000000: begin
                decodeNext.destReg  = rdField;
                decodeNext.regWrite = 1'b1;
                case (funct)
                    6'b100000: decodeNext.aluOp = aluAdd;
                    6'b100010: decodeNext.aluOp = aluSub;
                    6'b100100: decodeNext.aluOp = aluAnd;
                    6'b100101: decodeNext.aluOp = aluOr;
                    6'b100111: decodeNext.aluOp = aluNor;
                    6'b100110: decodeNext.aluOp = aluXor;
                    6'b101010: decodeNext.aluOp = aluSlt;
                    6'b000000: begin
                        decodeNext.aluOp = aluSll;
                        decodeNext.imm   = {27'b0, instr[10:6]};
                    end
                    6'b000010: begin
                        decodeNext.aluOp = aluSrl;
                        decodeNext.imm   = {27'b0, instr[10:6]};
                    end
                    6'b001000: begin
                        decodeNext.jumpReg  = 1'b1;
                        decodeNext.regWrite = 1'b0;
                    end
                    default: decodeNext.regWrite = 1'b0;
                endcase
            end
            // MUL, low half of product to rd
            6'b011100: begin
                decodeNext.destReg  = rdField;
                decodeNext.regWrite = 1'b1;
                decodeNext.aluOp    = aluMul;
            end
            6'b001100, 6'b001101, 6'b001110: begin
                decodeNext.imm      = immZero;
                decodeNext.aluSrc   = 1'b1;
                decodeNext.regWrite = 1'b1;
                decodeNext.aluOp    = (opcode == 6'b001100) ? aluAnd :
                                      (opcode == 6'b001101) ? aluOr : aluXor;
            end
            6'b001000, 6'b001010: begin
                decodeNext.aluSrc   = 1'b1;
                decodeNext.regWrite = 1'b1;
                decodeNext.aluOp    = (opcode == 6'b001000) ? aluAdd : aluSlt;
            end
            // Loads
            6'b100011, 6'b100001, 6'b100000: begin
                decodeNext.aluOp     = aluAdd;
                decodeNext.aluSrc    = 1'b1;
                decodeNext.regWrite  = 1'b1;
                decodeNext.memRead   = 1'b1;
                decodeNext.memSigned = (opcode != 6'b100011);
                decodeNext.memSize   = (opcode == 6'b100011) ? memWord :
                                       (opcode == 6'b100001) ? memHalf : memByte;
            end
            // Stores
            6'b101011, 6'b101001, 6'b101000: begin
                decodeNext.aluOp    = aluAdd;
                decodeNext.aluSrc   = 1'b1;
                decodeNext.memWrite = 1'b1;
                decodeNext.memSize  = (opcode == 6'b101011) ? memWord :
                                      (opcode == 6'b101001) ? memHalf : memByte;
            end
            // BGEZ and BLTZ share an opcode, rt picks
            6'b000001: begin
                case (rtAddr)
                    5'b00001: decodeNext.branchKind = brGez;
                    5'b00000: decodeNext.branchKind = brLtz;
                    default:  decodeNext.branchKind = brNone;
                endcase
            end
            6'b000100: decodeNext.branchKind = brEq;
            6'b000101: decodeNext.branchKind = brNe;
            6'b000111: decodeNext.branchKind = brGtz;
            6'b000110: decodeNext.branchKind = brLez;
            6'b000010: decodeNext.jump = 1'b1;
            6'b000011: begin
                decodeNext.jump     = 1'b1;
                decodeNext.link     = 1'b1;
                decodeNext.regWrite = 1'b1;
                decodeNext.destReg  = 5'd31;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decodeOut.valid <= 1'b0;
        end else if (fetchOut.valid) begin
            decodeOut <= decodeNext;
        end else begin
            decodeOut.valid <= 1'b0;
        end
    end

endmodule

/* verilog/fetchStage.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module fetchStage import cpuPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      retire,
    input  word_t     retirePc,
    output logic      iCyc,
    output logic      iStb,
    output word_t     iAdr,
    input  word_t     iDatIn,
    input  logic      iAck,
    output fetchOut_t fetchOut
);

    typedef enum logic [1:0] {idle, request, hold} fetchState_t;

    fetchState_t state;
    word_t       pc;

    // One bus cycle per instruction with nothing else in flight
    assign iCyc = (state == request);
    assign iStb = (state == request);
    assign iAdr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= idle;
            pc             <= `CPU_RESET_PC;
            fetchOut.valid <= 1'b0;
        end else begin
            fetchOut.valid <= 1'b0;
            case (state)
                idle: state <= request;
                request: begin
                    if (iAck) begin
                        fetchOut <= '{pc: pc, instr: iDatIn, valid: 1'b1};
                        state    <= hold;
                    end
                end
                default: begin
                    // Wait for the memory stage to finish
                    if (retire) begin
                        pc    <= retirePc;
                        state <= request;
                    end
                end
            endcase
        end
    end

    // A retire only comes back while the fetched instruction is in flight
    assert property (@(posedge clk) disable iff (rst) retire |-> (state == hold));

endmodule

/* verilog/executeStage.sv */
`timescale 1ns/1ps

module executeStage import cpuPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  decodeOut_t decodeOut,
    output execOut_t   execOut
);

    word_t    opA;
    word_t    opB;
    word_t    aluResult;
    word_t    pcPlus4;
    word_t    branchTarget;
    logic     taken;
    execOut_t execNext;

    assign opA          = decodeOut.rsVal;
    assign opB          = decodeOut.aluSrc ? decodeOut.imm : decodeOut.rtVal;
    assign pcPlus4      = decodeOut.pc + 32'd4;
    assign branchTarget = pcPlus4 + {decodeOut.imm[29:0], 2'b00};

    //////////////////////////////////////////////////////////////////////
    // ALU

    always_comb begin
        case (decodeOut.aluOp)
            aluAdd:  aluResult = opA + opB;
            aluSub:  aluResult = opA - opB;
            aluAnd:  aluResult = opA & opB;
            aluOr:   aluResult = opA | opB;
            aluNor:  aluResult = ~(opA | opB);
            aluXor:  aluResult = opA ^ opB;
            aluSlt:  aluResult = {31'b0, $signed(opA) < $signed(opB)};
            // Shifts act on rt, shamt sits in imm
            aluSll:  aluResult = decodeOut.rtVal << decodeOut.imm[4:0];
            aluSrl:  aluResult = decodeOut.rtVal >> decodeOut.imm[4:0];
            aluMul:  aluResult = opA * opB;
            default: aluResult = opB;
        endcase
    end

    // Branch test on rs, rt only for eq/ne
    always_comb begin
        case (decodeOut.branchKind)
            brEq:    taken = (opA == decodeOut.rtVal);
            brNe:    taken = (opA != decodeOut.rtVal);
            brGtz:   taken = ($signed(opA) > 0);
            brLez:   taken = ($signed(opA) <= 0);
            brGez:   taken = !opA[31];
            brLtz:   taken = opA[31];
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        execNext.result    = decodeOut.link ? pcPlus4 : aluResult;
        execNext.storeData = decodeOut.rtVal;
        execNext.nextPc    = taken             ? branchTarget :
                             decodeOut.jump    ? decodeOut.jumpTarget :
                             decodeOut.jumpReg ? decodeOut.rsVal : pcPlus4;
        execNext.destReg   = decodeOut.destReg;
        execNext.memRead   = decodeOut.memRead;
        execNext.memWrite  = decodeOut.memWrite;
        execNext.memSize   = decodeOut.memSize;
        execNext.memSigned = decodeOut.memSigned;
        execNext.regWrite  = decodeOut.regWrite;
        execNext.valid     = decodeOut.valid;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            execOut.valid <= 1'b0;
        end else if (decodeOut.valid) begin
            execOut <= execNext;
        end else begin
            execOut.valid <= 1'b0;
        end
    end

endmodule

/* verilog/memStage.sv */
`timescale 1ns/1ps

module memStage import cpuPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  execOut_t   execOut,
    output logic       dCyc,
    output logic       dStb,
    output logic       dWe,
    output word_t      dAdr,
    output logic [3:0] dSel,
    output word_t      dDatOut,
    input  word_t      dDatIn,
    input  logic       dAck,
    output logic       retire,
    output word_t      retirePc,
    output logic       wrEn,
    output regAddr_t   wrAddr,
    output word_t      wrData
);

    typedef enum logic [1:0] {idle, access, done} memState_t;

    memState_t  state;
    execOut_t   held;
    word_t      loadWord;
    word_t      laneShifted;
    word_t      loadValue;
    logic [1:0] byteOff;

    assign byteOff = held.result[1:0];

    //////////////////////////////////////////////////////////////////////
    // Data bus, little-endian lanes

    assign dCyc = (state == access);
    assign dStb = (state == access);
    assign dWe  = (state == access) && held.memWrite;
    assign dAdr = {held.result[31:2], 2'b00};

    always_comb begin
        case (held.memSize)
            memByte: begin
                dSel    = 4'b0001 << byteOff;
                dDatOut = {4{held.storeData[7:0]}};
            end
            memHalf: begin
                dSel    = byteOff[1] ? 4'b1100 : 4'b0011;
                dDatOut = {2{held.storeData[15:0]}};
            end
            default: begin
                dSel    = 4'b1111;
                dDatOut = held.storeData;
            end
        endcase
    end

    // Pick the addressed lane, then extend
    assign laneShifted = loadWord >> {byteOff, 3'b000};

    always_comb begin
        case (held.memSize)
            memByte: loadValue = {{24{held.memSigned & laneShifted[7]}}, laneShifted[7:0]};
            memHalf: loadValue = {{16{held.memSigned & laneShifted[15]}}, laneShifted[15:0]};
            default: loadValue = loadWord;
        endcase
    end

    // Retire and writeback share the done cycle
    assign retire   = (state == done);
    assign retirePc = held.nextPc;
    assign wrEn     = (state == done) && held.regWrite;
    assign wrAddr   = held.destReg;
    assign wrData   = held.memRead ? loadValue : held.result;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (execOut.valid) begin
                        state <= (execOut.memRead || execOut.memWrite) ? access : done;
                    end
                end
                access: begin
                    if (dAck) begin
                        state <= done;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (execOut.valid) begin
            held <= execOut;
        end
        if (state == access && dAck) begin
            loadWord <= dDatIn;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (dStb && !dAck) |=> $stable(dAdr));

endmodule

/* verilog/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; (
    input  logic       clk,
    input  logic       rst,
    // Instruction bus
    output logic       iCyc,
    output logic       iStb,
    output word_t      iAdr,
    input  word_t      iDatIn,
    input  logic       iAck,
    // Data bus
    output logic       dCyc,
    output logic       dStb,
    output logic       dWe,
    output word_t      dAdr,
    output logic [3:0] dSel,
    output word_t      dDatOut,
    input  word_t      dDatIn,
    input  logic       dAck
);

    fetchOut_t  fetchOut;
    decodeOut_t decodeOut;
    execOut_t   execOut;
    regAddr_t   rsAddr;
    regAddr_t   rtAddr;
    word_t      rsData;
    word_t      rtData;
    logic       retire;
    word_t      retirePc;
    logic       wrEn;
    regAddr_t   wrAddr;
    word_t      wrData;

    fetchStage uFetch (
        .clk(clk), .rst(rst), .retire(retire), .retirePc(retirePc),
        .iCyc(iCyc), .iStb(iStb), .iAdr(iAdr), .iDatIn(iDatIn), .iAck(iAck),
        .fetchOut(fetchOut)
    );

    decodeStage uDecode (
        .clk(clk), .rst(rst), .fetchOut(fetchOut),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .rsData(rsData), .rtData(rtData),
        .decodeOut(decodeOut)
    );

    regFile uRegFile (
        .clk(clk), .rst(rst),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .rsData(rsData), .rtData(rtData),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
    );

    executeStage uExecute (
        .clk(clk), .rst(rst), .decodeOut(decodeOut), .execOut(execOut)
    );

    memStage uMem (
        .clk(clk), .rst(rst), .execOut(execOut),
        .dCyc(dCyc), .dStb(dStb), .dWe(dWe), .dAdr(dAdr), .dSel(dSel),
        .dDatOut(dDatOut), .dDatIn(dDatIn), .dAck(dAck),
        .retire(retire), .retirePc(retirePc),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
    );

endmodule

/* testbench/tbCpu.sv */
`timescale 1ns/1ps

module tbCpu import cpuPkg::*; ();

    localparam int opSpecial = 'b000000;
    localparam int opRegimm  = 'b000001;
    localparam int opJ       = 'b000010;
    localparam int opJal     = 'b000011;
    localparam int opBeq     = 'b000100;
    localparam int opBne     = 'b000101;
    localparam int opBlez    = 'b000110;
    localparam int opBgtz    = 'b000111;
    localparam int opAddi    = 'b001000;
    localparam int opSlti    = 'b001010;
    localparam int opAndi    = 'b001100;
    localparam int opOri     = 'b001101;
    localparam int opXori    = 'b001110;
    localparam int opMul     = 'b011100;
    localparam int opLb      = 'b100000;
    localparam int opLh      = 'b100001;
    localparam int opLw      = 'b100011;
    localparam int opSb      = 'b101000;
    localparam int opSh      = 'b101001;
    localparam int opSw      = 'b101011;
    // Every program ends with a store here
    localparam int doneAddr  = 'h3fc;
    localparam int waitLimit = 5000;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        iCyc;
    logic        iStb;
    word_t       iAdr;
    word_t       iDatIn = '0;
    logic        iAck = 1'b0;
    logic        dCyc;
    logic        dStb;
    logic        dWe;
    word_t       dAdr;
    logic [3:0]  dSel;
    word_t       dDatOut;
    word_t       dDatIn = '0;
    logic        dAck = 1'b0;

    word_t       progBuf [256];
    word_t       ram [256];
    word_t       laneMask;
    logic [31:0] lcgState = 32'h3f01_db8d;
    logic        randomWaits = 1'b0;
    logic        doneSeen = 1'b0;
    logic        iBusy = 1'b0;
    logic        dBusy = 1'b0;
    int          iWait;
    int          dWait;
    int          progLen;
    int          checks = 0;
    int          errors = 0;

    cpuTop dut (
        .clk(clk), .rst(rst),
        .iCyc(iCyc), .iStb(iStb), .iAdr(iAdr), .iDatIn(iDatIn), .iAck(iAck),
        .dCyc(dCyc), .dStb(dStb), .dWe(dWe), .dAdr(dAdr), .dSel(dSel),
        .dDatOut(dDatOut), .dDatIn(dDatIn), .dAck(dAck)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers

    function automatic word_t lcgNext(input word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int ackDelay();
        lcgState = lcgNext(lcgState);
        if (randomWaits) begin
            return int'(lcgState[17:16]);
        end
        return 0;
    endfunction

    // RAM contents after reset, one value per word address
    function automatic word_t fillWord(input int idx);
        return (idx * 32'h0101_0101) ^ 32'ha5c3_0f96;
    endfunction

    function automatic word_t ramAt(input int addr);
        return ram[addr[9:2]];
    endfunction

    function automatic word_t sextByte(input logic [7:0] b);
        return {{24{b[7]}}, b};
    endfunction

    function automatic word_t sextHalf(input logic [15:0] h);
        return {{16{h[15]}}, h};
    endfunction

    function automatic word_t encR(input int op, input int rs, input int rt, input int rd,
                                   input int shamt, input int funct);
        return {op[5:0], rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct[5:0]};
    endfunction

    function automatic word_t encI(input int op, input int rs, input int rt, input int imm);
        return {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic word_t encJ(input int op, input int index);
        return {op[5:0], index[25:0]};
    endfunction

    // Architectural branch rule on rs and rt
    function automatic logic branchTaken(input int kind, input word_t a, input word_t b);
        case (kind)
            0: return a == b;
            1: return a != b;
            2: return $signed(a) > 0;
            3: return $signed(a) <= 0;
            4: return $signed(a) >= 0;
            default: return $signed(a) < 0;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Wishbone slave models driven shortly after each rising edge

    always @(posedge clk) begin
        #2;
        if (rst) begin
            iAck = 1'b0;
            dAck = 1'b0;
            iBusy = 1'b0;
            dBusy = 1'b0;
            doneSeen = 1'b0;
            for (int i = 0; i < 256; i++) begin
                ram[i] = fillWord(i);
            end
        end else begin
            // Both masters raise cyc and stb together
            if (iCyc !== iStb || dCyc !== dStb) begin
                $display("error at %0t ns: cyc and stb differ on a bus", $time);
                errors++;
            end
            // Instruction ROM
            if (iAck) begin
                iAck = 1'b0;
                iBusy = 1'b0;
            end else if (iCyc && iStb) begin
                if (!iBusy) begin
                    iBusy = 1'b1;
                    iWait = ackDelay();
                end
                if (iWait == 0) begin
                    iAck = 1'b1;
                    iDatIn = progBuf[iAdr[9:2]];
                end else begin
                    iWait--;
                end
            end
            // Data RAM with byte lanes
            if (dAck) begin
                dAck = 1'b0;
                dBusy = 1'b0;
            end else if (dCyc && dStb) begin
                if (!dBusy) begin
                    dBusy = 1'b1;
                    dWait = ackDelay();
                end
                if (dWait == 0) begin
                    dAck = 1'b1;
                    if (dWe) begin
                        laneMask = {{8{dSel[3]}}, {8{dSel[2]}}, {8{dSel[1]}}, {8{dSel[0]}}};
                        ram[dAdr[9:2]] = (ram[dAdr[9:2]] & ~laneMask) | (dDatOut & laneMask);
                        if (dAdr == doneAddr) begin
                            doneSeen = 1'b1;
                        end
                    end else begin
                        dDatIn = ram[dAdr[9:2]];
                    end
                end else begin
                    dWait--;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Program loading and checks

    // Holds the core in reset while a new program goes in at address 0
    task automatic beginProgram();
        @(posedge clk);
        #1 rst = 1'b1;
        progLen = 0;
        for (int i = 0; i < 256; i++) begin
            progBuf[i] = '0;
        end
    endtask

    task automatic emit(input word_t w);
        progBuf[progLen[7:0]] = w;
        progLen++;
    endtask

    task automatic runProgram(input string name);
        int n;
        emit(encI(opAddi, 0, 1, 1));
        emit(encI(opSw, 0, 1, doneAddr));
        emit(encI(opBeq, 0, 0, -1));
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        checks++;
        if (iCyc !== 1'b0 || iStb !== 1'b0 || dCyc !== 1'b0 || dStb !== 1'b0 ||
            dWe !== 1'b0) begin
            $display("error at %0t ns: bus outputs not idle after reset", $time);
            errors++;
        end
        n = 0;
        while (!doneSeen && n < waitLimit) begin
            @(posedge clk);
            n++;
        end
        if (!doneSeen) begin
            $display("Timeout: the %s program never reached its final store", name);
            errors++;
        end
    endtask

    task automatic checkWord(input string what, input int addr, input word_t wanted);
        checks++;
        if (ramAt(addr) !== wanted) begin
            $display("error at %0t ns: %s at %h reads %h, expected %h",
                     $time, what, addr, ramAt(addr), wanted);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic arithTest(input logic withWaits);
        word_t a;
        word_t b;
        word_t wanted [11];
        int    functs [8];
        a = -77;
        b = 1234;
        functs = '{'b100000, 'b100010, 'b100100, 'b100101, 'b100111, 'b100110,
                   'b101010, 'b101010};
        wanted = '{a + b, a - b, a & b, a | b, ~(a | b), a ^ b,
                   {31'b0, $signed(a) < $signed(b)}, {31'b0, $signed(b) < $signed(a)},
                   a << 5, a >> 7, a * b};
        randomWaits = withWaits;
        beginProgram();
        emit(encI(opAddi, 0, 1, -77));
        emit(encI(opAddi, 0, 2, 1234));
        // Last SLT runs with the operands swapped
        for (int k = 0; k < 8; k++) begin
            emit(encR(opSpecial, k == 7 ? 2 : 1, k == 7 ? 1 : 2, 3, 0, functs[k]));
            emit(encI(opSw, 0, 3, 'h100 + 4 * k));
        end
        emit(encR(opSpecial, 0, 1, 3, 5, 'b000000));
        emit(encI(opSw, 0, 3, 'h120));
        emit(encR(opSpecial, 0, 1, 3, 7, 'b000010));
        emit(encI(opSw, 0, 3, 'h124));
        emit(encR(opMul, 1, 2, 3, 0, 'b000010));
        emit(encI(opSw, 0, 3, 'h128));
        if (withWaits) begin
            runProgram("arithmetic with wait states");
        end else begin
            runProgram("arithmetic");
        end
        for (int k = 0; k < 11; k++) begin
            checkWord("ALU result", 'h100 + 4 * k, wanted[k]);
        end
        randomWaits = 1'b0;
    endtask

    task automatic immediateTest();
        word_t a;
        a = -5;
        beginProgram();
        emit(encI(opAddi, 0, 1, -5));
        emit(encI(opAndi, 1, 2, 'h8f0f));
        emit(encI(opOri, 0, 3, 'h8001));
        emit(encI(opXori, 1, 4, 'hffff));
        emit(encI(opSlti, 1, 5, -3));
        emit(encI(opSlti, 1, 6, -7));
        emit(encI(opAddi, 1, 7, -32768));
        emit(encI(opAddi, 0, 0, 123));
        emit(encR(opSpecial, 1, 1, 0, 0, 'b100000));
        for (int r = 0; r < 8; r++) begin
            emit(encI(opSw, 0, r, 'h100 + 4 * r));
        end
        runProgram("immediate");
        checkWord("register 0", 'h100, 32'h0);
        checkWord("ADDI negative", 'h104, a);
        checkWord("ANDI zero-extended", 'h108, a & 32'h0000_8f0f);
        checkWord("ORI zero-extended", 'h10c, 32'h0000_8001);
        checkWord("XORI zero-extended", 'h110, a ^ 32'h0000_ffff);
        checkWord("SLTI true", 'h114, {31'b0, $signed(a) < -3});
        checkWord("SLTI false", 'h118, {31'b0, $signed(a) < -7});
        checkWord("ADDI sign-extended", 'h11c, a + 32'hffff_8000);
    endtask

    task automatic loadStoreTest();
        word_t v;
        word_t exp200;
        word_t exp204;
        word_t f131;
        v = 32'hffff_a5c3;
        exp200 = fillWord(128);
        exp200[15:8] = v[7:0];
        exp204 = fillWord(129);
        exp204[31:16] = v[15:0];
        f131 = fillWord(131);
        beginProgram();
        emit(encI(opAddi, 0, 1, 'ha5c3));
        emit(encI(opSb, 0, 1, 'h201));
        emit(encI(opSh, 0, 1, 'h206));
        emit(encI(opSw, 0, 1, 'h208));
        emit(encI(opLb, 0, 2, 'h201));
        emit(encI(opLh, 0, 3, 'h206));
        emit(encI(opLw, 0, 4, 'h208));
        emit(encI(opLb, 0, 5, 'h20e));
        emit(encI(opLh, 0, 6, 'h20c));
        emit(encI(opLb, 0, 7, 'h203));
        for (int r = 2; r < 8; r++) begin
            emit(encI(opSw, 0, r, 'h300 + 4 * (r - 2)));
        end
        runProgram("load and store");
        checkWord("SB lanes", 'h200, exp200);
        checkWord("SH lanes", 'h204, exp204);
        checkWord("SW word", 'h208, v);
        checkWord("untouched word", 'h20c, f131);
        checkWord("LB stored byte", 'h300, sextByte(v[7:0]));
        checkWord("LH stored half", 'h304, sextHalf(v[15:0]));
        checkWord("LW word", 'h308, v);
        checkWord("LB lane 2", 'h30c, sextByte(f131[23:16]));
        checkWord("LH low half", 'h310, sextHalf(f131[15:0]));
        checkWord("LB lane 3", 'h314, sextByte(exp200[31:24]));
    endtask

    task automatic branchTest();
        word_t vals [5];
        int    kinds [12];
        int    rsSel [12];
        int    rtSel [12];
        int    ops [6];
        int    rtField;
        logic  taken;
        vals  = '{0, 5, -3, 0, 5};
        kinds = '{0, 0, 1, 1, 2, 2, 3, 3, 4, 4, 5, 5};
        rsSel = '{1, 1, 1, 1, 1, 3, 3, 1, 3, 2, 2, 3};
        rtSel = '{4, 2, 2, 4, 0, 0, 0, 0, 0, 0, 0, 0};
        ops   = '{opBeq, opBne, opBgtz, opBlez, opRegimm, opRegimm};
        beginProgram();
        emit(encI(opAddi, 0, 1, 5));
        emit(encI(opAddi, 0, 2, -3));
        emit(encI(opAddi, 0, 4, 5));
        // Fall-through marker, skip, then target marker
        for (int k = 0; k < 12; k++) begin
            rtField = kinds[k] < 2 ? rtSel[k] : (kinds[k] == 4 ? 1 : 0);
            emit(encI(ops[kinds[k]], rsSel[k], rtField, 3));
            emit(encI(opAddi, 0, 9, 'h0f00 + k));
            emit(encI(opSw, 0, 9, 'h100 + 4 * k));
            emit(encI(opBeq, 0, 0, 2));
            emit(encI(opAddi, 0, 9, 'h7a00 + k));
            emit(encI(opSw, 0, 9, 'h100 + 4 * k));
        end
        runProgram("branch");
        for (int k = 0; k < 12; k++) begin
            taken = branchTaken(kinds[k], vals[rsSel[k]], vals[rtSel[k]]);
            checkWord("branch marker", 'h100 + 4 * k, taken ? 'h7a00 + k : 'h0f00 + k);
        end
    endtask

    task automatic jumpTest();
        beginProgram();
        emit(encI(opAddi, 0, 5, 'h11));
        emit(encJ(opJ, 3));
        emit(encI(opSw, 0, 5, 'h100));
        // JAL sits at address 12
        emit(encJ(opJal, 6));
        emit(encI(opSw, 0, 31, 'h104));
        emit(encJ(opJ, 8));
        emit(encI(opSw, 0, 31, 'h108));
        emit(encR(opSpecial, 31, 0, 0, 0, 'b001000));
        runProgram("jump");
        checkWord("store skipped by J", 'h100, fillWord('h100 >> 2));
        checkWord("JAL link value", 'h108, 12 + 4);
        checkWord("store after JR return", 'h104, 12 + 4);
    endtask

    initial begin
        arithTest(1'b0);
        immediateTest();
        loadStoreTest();
        branchTest();
        jumpTest();
        arithTest(1'b1);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+common
common/cpuPkg.sv
decode/regFile.sv
decode/decodeStage.sv
verilog/fetchStage.sv
verilog/executeStage.sv
verilog/memStage.sv
verilog/cpuTop.sv
testbench/tbCpu.sv

/* Makefile */
SOURCES := $(filter-out +%,$(shell cat compile.f)) common/cpu_config.svh

obj_dir/VtbCpu: compile.f $(SOURCES)
	verilator --binary --timing --assert -f compile.f --top-module tbCpu -o VtbCpu

run: obj_dir/VtbCpu
	obj_dir/VtbCpu | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
